/* logic/rvfe_macros.svh */
`ifndef RVFE_MACROS_SVH
`define RVFE_MACROS_SVH

// global history length, also the table index width
`define RVFE_BHR_W 8

// 2-bit counters in the pattern table
`define RVFE_PHT_DEPTH 256

`define RVFE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RVFE_NOP 32'h0000_0013

`endif

/* logic/rvfe_pkg.sv */
package rvfe_pkg;

  // one word, register layout and store/branch layout
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } sb;
  } rv_instr_u;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    fmt_none,
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j
  } imm_fmt_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       valid;
    imm_fmt_e   fmt;
  } ctrl_word_t;

  // B-type offset, shared by fetch steering and decode
  function automatic logic [31:0] b_offset(rv_instr_u w);
    return {{20{w.sb.imm_hi[6]}}, w.sb.imm_lo[0], w.sb.imm_hi[5:0],
            w.sb.imm_lo[4:1], 1'b0};
  endfunction

endpackage : rvfe_pkg

/* logic/fetch_unit.sv */
`timescale 1ns/10ps
`include "rvfe_macros.svh"

module fetch_unit
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   stall,
  input  logic                   resolve_valid,
  input  logic                   resolve_taken,
  input  logic                   resolve_mispredict,
  input  logic [31:0]            resolve_pc,
  input  logic [31:0]            resolve_target,
  input  logic [`RVFE_BHR_W-1:0] resolve_bhr,
  output logic [31:0]            imem_addr,
  input  rvfe_pkg::rv_instr_u    imem_rdata,
  output rvfe_pkg::rv_instr_u    instr,
  output logic [31:0]            pc,
  output logic [31:0]            pc_4,
  output logic                   pred,
  output logic [`RVFE_BHR_W-1:0] bhr,
  output logic                   fetch_valid,
  output logic                   redirect
);

  logic [31:0]            pc_q;
  logic [31:0]            pc_next;
  logic [`RVFE_BHR_W-1:0] bhr_q;
  logic [`RVFE_BHR_W-1:0] bhr_next;
  logic [1:0]             pht [`RVFE_PHT_DEPTH];
  logic                   started;
  logic                   is_branch;
  logic [`RVFE_BHR_W-1:0] fetch_idx;
  logic [`RVFE_BHR_W-1:0] resolve_idx;

  assign redirect  = resolve_valid & resolve_mispredict;

  assign imem_addr = pc_q;
  assign pc        = pc_q;
  assign pc_4      = pc_q + 32'd4;
  assign instr     = imem_rdata;
  assign bhr       = bhr_q;

  // pre-decode, only the opcode matters here
  assign is_branch = imem_rdata.sb.opcode == rvfe_pkg::op_branch;

  // gshare index
  assign fetch_idx   = pc_q[`RVFE_BHR_W+1:2] ^ bhr_q;
  assign resolve_idx = resolve_pc[`RVFE_BHR_W+1:2] ^ resolve_bhr;

  assign pred = is_branch & pht[fetch_idx][1];

  always_comb
  begin
    pc_next  = pc_q;
    bhr_next = bhr_q;
    if (redirect)
    begin
      pc_next  = resolve_target;
      bhr_next = {resolve_bhr[`RVFE_BHR_W-2:0], resolve_taken};
    end
    else if (!stall)
    begin
      if (is_branch)
      begin
        pc_next  = pred ? pc_q + rvfe_pkg::b_offset(imem_rdata) : pc_4;
        bhr_next = {bhr_q[`RVFE_BHR_W-2:0], pred};
      end
      else
      begin
        pc_next = pc_4;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc_q    <= `RVFE_RESET_PC;
      bhr_q   <= '0;
      started <= 1'b0;
    end
    else
    begin
      pc_q    <= pc_next;
      bhr_q   <= bhr_next;
      started <= 1'b1;
    end
  end

  // first word after reset is not handed on as valid
  assign fetch_valid = started;

  // counters train on every resolve, stall or not
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `RVFE_PHT_DEPTH; i++)
      begin
        pht[i] <= 2'b01;
      end
    end
    else if (resolve_valid)
    begin
      if (resolve_taken)
      begin
        if (pht[resolve_idx] != 2'b11)
        begin
          pht[resolve_idx] <= pht[resolve_idx] + 2'b01;
        end
      end
      else
      begin
        if (pht[resolve_idx] != 2'b00)
        begin
          pht[resolve_idx] <= pht[resolve_idx] - 2'b01;
        end
      end
    end
  end

endmodule : fetch_unit

/* logic/if_id_reg.sv */
`timescale 1ns/10ps
`include "rvfe_macros.svh"

module if_id_reg
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   stall,
  input  logic                   redirect,
  input  logic                   fetch_valid,
  input  rvfe_pkg::rv_instr_u    instr_in,
  input  logic [31:0]            pc_in,
  input  logic [31:0]            pc_4_in,
  input  logic                   pred_in,
  input  logic [`RVFE_BHR_W-1:0] bhr_in,
  output rvfe_pkg::rv_instr_u    instr_out,
  output logic [31:0]            pc_out,
  output logic [31:0]            pc_4_out,
  output logic                   pred_out,
  output logic [`RVFE_BHR_W-1:0] bhr_out,
  output logic                   valid
);

  // redirect wins over stall
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      instr_out <= `RVFE_NOP;
      valid     <= 1'b0;
    end
    else if (redirect)
    begin
      instr_out <= `RVFE_NOP;
      valid     <= 1'b0;
    end
    else if (!stall)
    begin
      instr_out <= instr_in;
      valid     <= fetch_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (redirect || !stall)
    begin
      pc_out   <= pc_in;
      pc_4_out <= pc_4_in;
      pred_out <= pred_in;
      bhr_out  <= bhr_in;
    end
  end

endmodule : if_id_reg

/* logic/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit
(
  input  rvfe_pkg::rv_instr_u  instr,
  input  logic                 valid,
  output rvfe_pkg::ctrl_word_t ctrl,
  output logic [31:0]          imm
);

  logic               known;
  logic               reg_write;
  logic               mem_read;
  logic               mem_write;
  logic               branch;
  logic               jump;
  rvfe_pkg::imm_fmt_e fmt;

  always_comb
  begin
    known     = 1'b1;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    fmt       = rvfe_pkg::fmt_none;
    case (instr.r.opcode)
      rvfe_pkg::op_lui,
      rvfe_pkg::op_auipc:
      begin
        fmt       = rvfe_pkg::fmt_u;
        reg_write = 1'b1;
      end
      rvfe_pkg::op_jal:
      begin
        fmt       = rvfe_pkg::fmt_j;
        reg_write = 1'b1;
        jump      = 1'b1;
      end
      rvfe_pkg::op_jalr:
      begin
        fmt       = rvfe_pkg::fmt_i;
        reg_write = 1'b1;
        jump      = 1'b1;
      end
      rvfe_pkg::op_branch:
      begin
        fmt    = rvfe_pkg::fmt_b;
        branch = 1'b1;
      end
      rvfe_pkg::op_load:
      begin
        fmt       = rvfe_pkg::fmt_i;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      rvfe_pkg::op_store:
      begin
        fmt       = rvfe_pkg::fmt_s;
        mem_write = 1'b1;
      end
      rvfe_pkg::op_imm:
      begin
        fmt       = rvfe_pkg::fmt_i;
        reg_write = 1'b1;
      end
      rvfe_pkg::op_reg:
      begin
        reg_write = 1'b1;
      end
      default:
      begin
        known = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    ctrl.opcode    = rvfe_pkg::opcode_e'(instr.r.opcode);
    ctrl.rd        = instr.r.rd;
    ctrl.rs1       = instr.r.rs1;
    ctrl.rs2       = instr.r.rs2;
    ctrl.funct3    = instr.r.funct3;
    ctrl.funct7    = instr.r.funct7;
    ctrl.fmt       = fmt;
    ctrl.valid     = valid & known;
    // flushed or empty slot must not act downstream
    ctrl.reg_write = valid & reg_write;
    ctrl.mem_read  = valid & mem_read;
    ctrl.mem_write = valid & mem_write;
    ctrl.branch    = valid & branch;
    ctrl.jump      = valid & jump;
  end

  // s and b from the split layout, the rest from the register layout
  always_comb
  begin
    case (fmt)
      rvfe_pkg::fmt_i: imm = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
      rvfe_pkg::fmt_s: imm = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
      rvfe_pkg::fmt_b: imm = rvfe_pkg::b_offset(instr);
      rvfe_pkg::fmt_u: imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
      rvfe_pkg::fmt_j: imm = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3,
                              instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};
      default:         imm = 32'd0;
    endcase
  end

endmodule : decode_unit

/* logic/rv_frontend.sv */
`timescale 1ns/10ps
`include "rvfe_macros.svh"

module rv_frontend
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   stall,
  input  logic                   resolve_valid,
  input  logic                   resolve_taken,
  input  logic                   resolve_mispredict,
  input  logic [31:0]            resolve_pc,
  input  logic [31:0]            resolve_target,
  input  logic [`RVFE_BHR_W-1:0] resolve_bhr,
  output logic [31:0]            imem_addr,
  input  rvfe_pkg::rv_instr_u    imem_rdata,
  output rvfe_pkg::ctrl_word_t   ctrl,
  output logic [31:0]            imm,
  output logic [31:0]            id_pc,
  output logic [31:0]            id_pc_4,
  output logic                   id_pred,
  output logic [`RVFE_BHR_W-1:0] id_bhr
);

  rvfe_pkg::rv_instr_u    if_instr;
  logic [31:0]            if_pc;
  logic [31:0]            if_pc_4;
  logic                   if_pred;
  logic [`RVFE_BHR_W-1:0] if_bhr;
  logic                   fetch_valid;
  logic                   redirect;
  rvfe_pkg::rv_instr_u    id_instr;
  logic                   id_valid;

  fetch_unit u_fetch_unit (
    .clk                (clk),
    .arst_n             (arst_n),
    .stall              (stall),
    .resolve_valid      (resolve_valid),
    .resolve_taken      (resolve_taken),
    .resolve_mispredict (resolve_mispredict),
    .resolve_pc         (resolve_pc),
    .resolve_target     (resolve_target),
    .resolve_bhr        (resolve_bhr),
    .imem_addr          (imem_addr),
    .imem_rdata         (imem_rdata),
    .instr              (if_instr),
    .pc                 (if_pc),
    .pc_4               (if_pc_4),
    .pred               (if_pred),
    .bhr                (if_bhr),
    .fetch_valid        (fetch_valid),
    .redirect           (redirect)
  );

  if_id_reg u_if_id_reg (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .redirect    (redirect),
    .fetch_valid (fetch_valid),
    .instr_in    (if_instr),
    .pc_in       (if_pc),
    .pc_4_in     (if_pc_4),
    .pred_in     (if_pred),
    .bhr_in      (if_bhr),
    .instr_out   (id_instr),
    .pc_out      (id_pc),
    .pc_4_out    (id_pc_4),
    .pred_out    (id_pred),
    .bhr_out     (id_bhr),
    .valid       (id_valid)
  );

  decode_unit u_decode_unit (
    .instr (id_instr),
    .valid (id_valid),
    .ctrl  (ctrl),
    .imm   (imm)
  );

endmodule : rv_frontend

/* testbench/rv_frontend_properties.sv */
`timescale 1ns/10ps

module rv_frontend_properties
(
  input logic                 clk,
  input logic                 arst_n,
  input logic                 stall,
  input logic                 resolve_valid,
  input logic                 resolve_mispredict,
  input logic [31:0]          resolve_target,
  input logic [31:0]          imem_addr,
  input rvfe_pkg::ctrl_word_t ctrl
);

  logic any_enable;

  assign any_enable = ctrl.reg_write | ctrl.mem_read | ctrl.mem_write | ctrl.branch | ctrl.jump;

  // an empty slot drives nothing downstream
  enables_need_valid: assert property (@(posedge clk) disable iff (!arst_n)
    !ctrl.valid |-> !any_enable)
  else $error("ctrl enable active while ctrl.valid is low");

  pc_holds_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
    stall && !resolve_valid |=> $stable(imem_addr))
  else $error("imem_addr moved during a stall cycle");

  flush_on_mispredict: assert property (@(posedge clk) disable iff (!arst_n)
    resolve_valid && resolve_mispredict |=> !ctrl.valid && imem_addr == $past(resolve_target))
  else $error("mispredict did not flush IF/ID and redirect fetch");

endmodule : rv_frontend_properties

bind rv_frontend rv_frontend_properties u_rv_frontend_properties (
  .clk                (clk),
  .arst_n             (arst_n),
  .stall              (stall),
  .resolve_valid      (resolve_valid),
  .resolve_mispredict (resolve_mispredict),
  .resolve_target     (resolve_target),
  .imem_addr          (imem_addr),
  .ctrl               (ctrl)
);

/* testbench/rv_frontend_tb.sv */
`timescale 1ns/10ps
`include "rvfe_macros.svh"

module rv_frontend_tb;

  localparam int cycle_limit = 2500;
  localparam int test_len    = 300;

  logic                   clk;
  logic                   arst_n;
  logic                   stall;
  logic                   resolve_valid;
  logic                   resolve_taken;
  logic                   resolve_mispredict;
  logic [31:0]            resolve_pc;
  logic [31:0]            resolve_target;
  logic [`RVFE_BHR_W-1:0] resolve_bhr;
  logic [31:0]            imem_addr;
  rvfe_pkg::rv_instr_u    imem_rdata;
  rvfe_pkg::ctrl_word_t   ctrl;
  logic [31:0]            imm;
  logic [31:0]            id_pc;
  logic [31:0]            id_pc_4;
  logic                   id_pred;
  logic [`RVFE_BHR_W-1:0] id_bhr;

  int          seed = 32'hd9769e5b;
  int          cycles = 0;
  int          checks;
  int          errors;
  int          start_checks;
  int          start_errors;
  logic [31:0] imem [1024];

  // reference model: fetch state, counters and one-deep IF/ID copy
  logic [31:0]            m_pc;
  logic [`RVFE_BHR_W-1:0] m_bhr;
  logic [1:0]             m_pht [`RVFE_PHT_DEPTH];
  logic                   m_started;
  logic [31:0]            q_word;
  logic [31:0]            q_pc;
  logic [31:0]            q_pc_4;
  logic                   q_pred;
  logic [`RVFE_BHR_W-1:0] q_bhr;
  logic                   q_valid;
  logic                   hold_due;
  logic                   flush_due;
  logic [31:0]            flush_target;
  logic [31:0]            prev_addr;
  rvfe_pkg::ctrl_word_t   prev_ctrl;
  logic [31:0]            prev_imm;
  logic [31:0]            prev_pc;
  logic [31:0]            prev_pc_4;
  logic                   prev_pred;
  logic [`RVFE_BHR_W-1:0] prev_bhr;

  rv_frontend u_rv_frontend (
    .clk                (clk),
    .arst_n             (arst_n),
    .stall              (stall),
    .resolve_valid      (resolve_valid),
    .resolve_taken      (resolve_taken),
    .resolve_mispredict (resolve_mispredict),
    .resolve_pc         (resolve_pc),
    .resolve_target     (resolve_target),
    .resolve_bhr        (resolve_bhr),
    .imem_addr          (imem_addr),
    .imem_rdata         (imem_rdata),
    .ctrl               (ctrl),
    .imm                (imm),
    .id_pc              (id_pc),
    .id_pc_4            (id_pc_4),
    .id_pred            (id_pred),
    .id_bhr             (id_bhr)
  );

  // combinational instruction memory
  assign imem_rdata = imem[imem_addr[11:2]];

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ctrl(input string name, input rvfe_pkg::ctrl_word_t got,
                            input rvfe_pkg::ctrl_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // RV32I immediate formats, straight from the instruction bit positions
  function automatic logic [31:0] imm_expect(input logic [31:0] w, input rvfe_pkg::imm_fmt_e f);
    case (f)
      rvfe_pkg::fmt_i: return {{20{w[31]}}, w[31:20]};
      rvfe_pkg::fmt_s: return {{20{w[31]}}, w[31:25], w[11:7]};
      rvfe_pkg::fmt_b: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      rvfe_pkg::fmt_u: return {w[31:12], 12'd0};
      rvfe_pkg::fmt_j: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default:         return 32'd0;
    endcase
  endfunction

  function automatic rvfe_pkg::ctrl_word_t decode_expect(input logic [31:0] w, input logic v);
    rvfe_pkg::ctrl_word_t c;
    rvfe_pkg::imm_fmt_e   f;
    logic [4:0]           en;
    logic                 known;
    case (w[6:0])
      7'b0110111, 7'b0010111: f = rvfe_pkg::fmt_u;
      7'b1101111:             f = rvfe_pkg::fmt_j;
      7'b1100111, 7'b0000011, 7'b0010011: f = rvfe_pkg::fmt_i;
      7'b1100011:             f = rvfe_pkg::fmt_b;
      7'b0100011:             f = rvfe_pkg::fmt_s;
      default:                f = rvfe_pkg::fmt_none;
    endcase
    // reg_write, mem_read, mem_write, branch, jump
    case (w[6:0])
      7'b0110111, 7'b0010111, 7'b0010011, 7'b0110011: en = 5'b10000;
      7'b1101111, 7'b1100111: en = 5'b10001;
      7'b1100011:             en = 5'b00010;
      7'b0000011:             en = 5'b11000;
      7'b0100011:             en = 5'b00100;
      default:                en = 5'b00000;
    endcase
    known = (f != rvfe_pkg::fmt_none) || (w[6:0] == 7'b0110011);
    c = '0;
    c.opcode = rvfe_pkg::opcode_e'(w[6:0]);
    c.rd     = w[11:7];
    c.funct3 = w[14:12];
    c.rs1    = w[19:15];
    c.rs2    = w[24:20];
    c.funct7 = w[31:25];
    c.fmt    = f;
    c.valid  = v & known;
    {c.reg_write, c.mem_read, c.mem_write, c.branch, c.jump} = v ? en : 5'b00000;
    return c;
  endfunction

  task automatic fill_memory(input logic with_branches);
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  op;
    for (int i = 0; i < 1024; i++)
    begin
      r = $random(seed);
      w = $random(seed);
      case (r[2:0])
        3'd0:    op = 7'b0110111;
        3'd1:    op = 7'b0010111;
        3'd2:    op = 7'b1101111;
        3'd3:    op = 7'b1100111;
        3'd4:    op = 7'b0000011;
        3'd5:    op = 7'b0100011;
        3'd6:    op = 7'b0010011;
        default: op = 7'b0110011;
      endcase
      // roughly one word in four becomes a conditional branch
      if (with_branches && r[4:3] == 2'b00)
      begin
        op   = 7'b1100011;
        w[8] = 1'b0;
      end
      imem[i] = {w[31:7], op};
    end
  endtask

  task automatic reset_model();
    m_pc      = `RVFE_RESET_PC;
    m_bhr     = '0;
    m_started = 1'b0;
    q_word    = `RVFE_NOP;
    q_valid   = 1'b0;
    hold_due  = 1'b0;
    flush_due = 1'b0;
    for (int i = 0; i < `RVFE_PHT_DEPTH; i++)
    begin
      m_pht[i] = 2'b01;
    end
  endtask

  task automatic drive_resolve(input logic allow_miss);
    logic [31:0] r;
    logic [31:0] t;
    r = $random(seed);
    t = $random(seed);
    resolve_valid      = r[0];
    resolve_taken      = r[2:1] != 2'b00;
    resolve_mispredict = allow_miss & (r[5:3] == 3'd0);
    // half the time train the entry the current fetch reads
    resolve_pc         = r[6] ? m_pc : {20'd0, t[11:2], 2'b00};
    resolve_bhr        = r[7] ? m_bhr : t[`RVFE_BHR_W+11:12];
    resolve_target     = {20'd0, t[31:22], 2'b00};
  endtask

  task automatic compare_outputs();
    rvfe_pkg::ctrl_word_t exp_ctrl;
    exp_ctrl = decode_expect(q_word, q_valid);
    check_word("imem_addr", imem_addr, m_pc);
    check_ctrl("ctrl", ctrl, exp_ctrl);
    check_word("imm", imm, imm_expect(q_word, exp_ctrl.fmt));
    if (q_valid)
    begin
      check_word("id_pc", id_pc, q_pc);
      check_word("id_pc_4", id_pc_4, q_pc_4);
      check_bit("id_pred", id_pred, q_pred);
      check_word("id_bhr", 32'(id_bhr), 32'(q_bhr));
    end
    if (flush_due)
    begin
      check_bit("ctrl.valid after flush", ctrl.valid, 1'b0);
      check_word("imem_addr after flush", imem_addr, flush_target);
    end
    if (hold_due)
    begin
      check_word("imem_addr held", imem_addr, prev_addr);
      check_ctrl("ctrl held", ctrl, prev_ctrl);
      check_word("imm held", imm, prev_imm);
      check_word("id_pc held", id_pc, prev_pc);
      check_word("id_pc_4 held", id_pc_4, prev_pc_4);
      check_bit("id_pred held", id_pred, prev_pred);
      check_word("id_bhr held", 32'(id_bhr), 32'(prev_bhr));
    end
    prev_addr = imem_addr;
    prev_ctrl = ctrl;
    prev_imm  = imm;
    prev_pc   = id_pc;
    prev_pc_4 = id_pc_4;
    prev_pred = id_pred;
    prev_bhr  = id_bhr;
  endtask

  // state after the coming edge, from the inputs now stable
  task automatic update_model();
    logic [31:0]            word;
    logic [31:0]            b_imm;
    logic                   redir;
    logic                   is_br;
    logic                   p;
    logic [`RVFE_BHR_W-1:0] idx;
    logic [`RVFE_BHR_W-1:0] ridx;
    word  = imem[m_pc[11:2]];
    redir = resolve_valid & resolve_mispredict;
    is_br = word[6:0] == 7'b1100011;
    idx   = m_pc[`RVFE_BHR_W+1:2] ^ m_bhr;
    ridx  = resolve_pc[`RVFE_BHR_W+1:2] ^ resolve_bhr;
    p     = is_br & m_pht[idx][1];
    b_imm = imm_expect(word, rvfe_pkg::fmt_b);
    hold_due     = stall & ~redir;
    flush_due    = redir;
    flush_target = resolve_target;
    if (redir | ~stall)
    begin
      q_pc    = m_pc;
      q_pc_4  = m_pc + 32'd4;
      q_pred  = p;
      q_bhr   = m_bhr;
      q_word  = redir ? `RVFE_NOP : word;
      q_valid = ~redir & m_started;
    end
    if (resolve_valid & resolve_taken & (m_pht[ridx] != 2'b11))
    begin
      m_pht[ridx] = m_pht[ridx] + 2'b01;
    end
    else if (resolve_valid & ~resolve_taken & (m_pht[ridx] != 2'b00))
    begin
      m_pht[ridx] = m_pht[ridx] - 2'b01;
    end
    if (redir)
    begin
      m_pc  = resolve_target;
      m_bhr = {resolve_bhr[`RVFE_BHR_W-2:0], resolve_taken};
    end
    else if (!stall)
    begin
      if (is_br)
      begin
        m_bhr = {m_bhr[`RVFE_BHR_W-2:0], p};
      end
      m_pc = p ? m_pc + b_imm : m_pc + 32'd4;
    end
    m_started = 1'b1;
  endtask

  task automatic run_cycle();
    @(negedge clk);
    compare_outputs();
    update_model();
    @(posedge clk);
    #2;
  endtask

  task automatic start_test();
    start_checks = checks;
    start_errors = errors;
  endtask

  task automatic finish_test(input int n, input string name);
    $display("test %0d %s: %0d checks, %0d errors", n, name,
             checks - start_checks, errors - start_errors);
  endtask

  task automatic test_reset();
    start_test();
    repeat (4)
    begin
      @(negedge clk);
      check_word("imem_addr", imem_addr, `RVFE_RESET_PC);
      check_bit("ctrl.valid", ctrl.valid, 1'b0);
      check_bit("ctrl enables", ctrl.reg_write | ctrl.mem_read | ctrl.mem_write |
                ctrl.branch | ctrl.jump, 1'b0);
    end
    @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (4)
    begin
      run_cycle();
    end
    finish_test(1, "reset state");
  endtask

  task automatic test_sequential();
    logic [5:0]           fmt_seen;
    rvfe_pkg::ctrl_word_t seen_ctrl;
    start_test();
    fmt_seen = '0;
    fill_memory(1'b0);
    repeat (test_len)
    begin
      run_cycle();
      seen_ctrl = decode_expect(q_word, q_valid);
      fmt_seen[seen_ctrl.fmt] = 1'b1;
    end
    // no branch words here, so every format but b
    if (fmt_seen != 6'b110111)
    begin
      errors++;
      $display("not every non-branch immediate format reached decode, seen %b", fmt_seen);
    end
    finish_test(2, "sequential decode");
  endtask

  task automatic test_resolves(input int n, input string name, input logic allow_miss,
                               input logic with_stall);
    logic [31:0] r;
    start_test();
    fill_memory(1'b1);
    repeat (test_len)
    begin
      r = $random(seed);
      stall = with_stall & (r[1:0] == 2'b00);
      drive_resolve(allow_miss);
      run_cycle();
    end
    stall         = 1'b0;
    resolve_valid = 1'b0;
    finish_test(n, name);
  endtask

  initial
  begin
    arst_n             = 1'b0;
    stall              = 1'b0;
    resolve_valid      = 1'b0;
    resolve_taken      = 1'b0;
    resolve_mispredict = 1'b0;
    resolve_pc         = '0;
    resolve_target     = '0;
    resolve_bhr        = '0;
    checks             = 0;
    errors             = 0;
    fill_memory(1'b1);
    reset_model();
    test_reset();
    test_sequential();
    test_resolves(3, "prediction steering", 1'b0, 1'b0);
    test_resolves(4, "misprediction redirect", 1'b1, 1'b0);
    test_resolves(5, "stall", 1'b0, 1'b1);
    $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : rv_frontend_tb

/* rv_frontend.f */
+incdir+logic
logic/rvfe_pkg.sv
logic/fetch_unit.sv
logic/if_id_reg.sv
logic/decode_unit.sv
logic/rv_frontend.sv
testbench/rv_frontend_properties.sv
testbench/rv_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the rv_frontend testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv_frontend_tb -f rv_frontend.f \
  -o rv_frontend_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/rv_frontend_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
